// ==== hw/hci_size_pkg.sv ====
// geometry of the shared-memory subsystem
// byte addresses are word aligned, and the low bits only select byte lanes
// id_w must cover nb_chan, because the id is the source channel index
// fifo_depth of 1 or more, and a power of two is not required
package hci_size_pkg;

  // initiator channels and the id that tags them
  localparam int unsigned nb_chan    = 4;
  localparam int unsigned id_w       = 2;

  // data path
  localparam int unsigned data_w     = 32;
  localparam int unsigned be_w       = 4;
  localparam int unsigned byte_w     = data_w / be_w;

  // byte address split into word index and byte offset
  localparam int unsigned addr_w     = 10;
  localparam int unsigned mem_words  = 256;
  localparam int unsigned word_w     = $clog2(mem_words);
  localparam int unsigned byte_off_w = $clog2(be_w);

  // fifo geometry, with the counter one bit wider to hold the full state
  localparam int unsigned fifo_depth = 2;
  localparam int unsigned fifo_ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int unsigned fifo_cnt_w = $clog2(fifo_depth + 1);

endpackage

// ==== hw/hci_bus_pkg.sv ====
// request and response payloads of the interconnect
// wen high means read, wen low means write with byte enables
// every request gets a response, so writes also return r_data (don't care)
// the id is added by the multiplexer and is not part of the channel payload
package hci_bus_pkg;

  // full request behind the multiplexer, 49 bits
  typedef struct packed {
    logic [hci_size_pkg::addr_w-1:0] add;
    logic                            wen;
    logic [hci_size_pkg::be_w-1:0]   be;
    logic [hci_size_pkg::data_w-1:0] data;
    logic [hci_size_pkg::id_w-1:0]   id;
  } hci_req_t;

  // response with the id reflected back, 34 bits
  typedef struct packed {
    logic [hci_size_pkg::data_w-1:0] r_data;
    logic [hci_size_pkg::id_w-1:0]   r_id;
  } hci_rsp_t;

  // request as issued by a channel, no id yet, 47 bits
  typedef struct packed {
    logic [hci_size_pkg::addr_w-1:0] add;
    logic                            wen;
    logic [hci_size_pkg::be_w-1:0]   be;
    logic [hci_size_pkg::data_w-1:0] data;
  } hci_chan_req_t;

endpackage

// ==== hw/hci_sram_bank.sv ====
// single-port word memory, one access per cycle
// read data is registered and valid the cycle after en_i
// rdata_o holds its last value on writes and idle cycles
// no reset, contents are unknown until written
`timescale 1ns/100ps

module hci_sram_bank (
  input  logic                            clk_i,
  input  logic                            en_i,
  input  logic                            we_i,
  input  logic [hci_size_pkg::word_w-1:0] addr_i,
  input  logic [hci_size_pkg::be_w-1:0]   be_i,
  input  logic [hci_size_pkg::data_w-1:0] wdata_i,
  output logic [hci_size_pkg::data_w-1:0] rdata_o
);

  logic [hci_size_pkg::data_w-1:0] mem_q [hci_size_pkg::mem_words];
  logic [hci_size_pkg::data_w-1:0] rdata_q;

  // byte-masked write
  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      for (int b = 0; b < hci_size_pkg::be_w; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*hci_size_pkg::byte_w +: hci_size_pkg::byte_w] <=
              wdata_i[b*hci_size_pkg::byte_w +: hci_size_pkg::byte_w];
        end
      end
    end
  end

  // registered read, no write-through
  always_ff @(posedge clk_i) begin
    if (en_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/hci_id_fifo.sv ====
// circular-buffer FIFO for request or response payloads, id kept unchanged
// pushed data shows up at the pop side one cycle later
// free_o looks at the occupancy after this cycle's handshakes, so a slot
// promised to a push in the next cycle is never handed out twice
// clear_i drops all entries, use it only when nothing is in flight
`timescale 1ns/100ps

module hci_id_fifo #(
  parameter type payload_t = hci_bus_pkg::hci_req_t
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  logic     push_req_i,
  output logic     push_gnt_o,
  input  payload_t push_data_i,
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o,
  output logic     free_o
);

  payload_t                          mem_q [hci_size_pkg::fifo_depth];
  logic [hci_size_pkg::fifo_ptr_w-1:0] wr_ptr_q;
  logic [hci_size_pkg::fifo_ptr_w-1:0] rd_ptr_q;
  logic [hci_size_pkg::fifo_cnt_w-1:0] count_q;
  logic [hci_size_pkg::fifo_cnt_w-1:0] count_d;
  logic                              push_hs;
  logic                              pop_hs;

  // full blocks the push side, empty blocks the pop side
  assign push_gnt_o  = count_q < (hci_size_pkg::fifo_cnt_w)'(hci_size_pkg::fifo_depth);
  assign pop_valid_o = count_q != '0;
  assign push_hs     = push_req_i & push_gnt_o;
  assign pop_hs      = pop_valid_o & pop_ready_i;

  always_comb begin
    count_d = count_q;
    if (push_hs && !pop_hs) begin
      count_d = count_q + 1'b1;
    end else if (pop_hs && !push_hs) begin
      count_d = count_q - 1'b1;
    end
  end

  // slot still free once this cycle's push and pop have settled
  assign free_o = count_d < (hci_size_pkg::fifo_cnt_w)'(hci_size_pkg::fifo_depth);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      count_q <= count_d;
      // pointers wrap at depth-1, depth need not be a power of two
      if (push_hs) begin
        if (wr_ptr_q == (hci_size_pkg::fifo_ptr_w)'(hci_size_pkg::fifo_depth - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop_hs) begin
        if (rd_ptr_q == (hci_size_pkg::fifo_ptr_w)'(hci_size_pkg::fifo_depth - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_hs) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o = mem_q[rd_ptr_q];

endmodule

// ==== hw/hci_r_id_filter.sv ====
// id reflector at the zero-latency boundary of the bank
// a request is taken only while the response FIFO has a free slot,
// so the response push one cycle later always lands
// writes get a response too, its r_data carries no meaning
`timescale 1ns/100ps

module hci_r_id_filter (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   req_valid_i,
  input  hci_bus_pkg::hci_req_t                  req_i,
  output logic                                   req_ready_o,
  input  logic                                   rsp_free_i,
  // bank port
  output logic                                   mem_en_o,
  output logic                                   mem_we_o,
  output logic [hci_size_pkg::word_w-1:0]        mem_addr_o,
  output logic [hci_size_pkg::be_w-1:0]          mem_be_o,
  output logic [hci_size_pkg::data_w-1:0]        mem_wdata_o,
  input  logic [hci_size_pkg::data_w-1:0]        mem_rdata_i,
  // response push
  output logic                                   rsp_push_o,
  output hci_bus_pkg::hci_rsp_t                  rsp_o
);

  logic                          req_hs;
  logic                          pending_q;
  logic [hci_size_pkg::id_w-1:0] id_q;

  assign req_ready_o = rsp_free_i;
  assign req_hs      = req_valid_i & rsp_free_i;

  // bank access in the same cycle as the pop, wen high is a read
  assign mem_en_o    = req_hs;
  assign mem_we_o    = ~req_i.wen;
  assign mem_addr_o  = req_i.add[hci_size_pkg::addr_w-1:hci_size_pkg::byte_off_w];
  assign mem_be_o    = req_i.be;
  assign mem_wdata_o = req_i.data;

  // one response owed for every accepted request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= req_hs;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      id_q <= req_i.id;
    end
  end

  // bank data arrives now, pair it with the stored id
  assign rsp_push_o   = pending_q;
  assign rsp_o.r_data = mem_rdata_i;
  assign rsp_o.r_id   = id_q;

endmodule

// ==== hw/hci_ooo_mux.sv ====
// N-to-1 request multiplexer with id-based response routing
// channels must hold req and payload stable until granted
// the winner id is stamped on each request, and anything downstream must
// return that id unchanged with the response
// responses may come back in any order, r_id alone selects the channel
// clear_i is synchronous and only touches the arbiter state
`timescale 1ns/100ps

module hci_ooo_mux (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 clear_i,
  input  logic                                                 priority_force_i,
  input  logic [hci_size_pkg::nb_chan-1:0][hci_size_pkg::id_w-1:0] priority_i,
  // channel side
  input  logic [hci_size_pkg::nb_chan-1:0]                     chan_req_i,
  output logic [hci_size_pkg::nb_chan-1:0]                     chan_gnt_o,
  output logic [hci_size_pkg::nb_chan-1:0]                     chan_r_valid_o,
  output logic [hci_size_pkg::nb_chan-1:0][hci_size_pkg::data_w-1:0] chan_r_data_o,
  input  logic [hci_size_pkg::nb_chan-1:0]                     chan_r_ready_i,
  input  hci_bus_pkg::hci_chan_req_t [hci_size_pkg::nb_chan-1:0] chan_payload_i,
  // memory side
  output logic                                                 out_req_o,
  input  logic                                                 out_gnt_i,
  output hci_bus_pkg::hci_req_t                                out_o,
  input  logic                                                 rsp_valid_i,
  input  hci_bus_pkg::hci_rsp_t                                rsp_i,
  output logic                                                 rsp_ready_o
);

  logic [hci_size_pkg::id_w-1:0]                           rr_counter_q;
  logic [hci_size_pkg::nb_chan-1:0][hci_size_pkg::id_w-1:0] rank_chan;
  logic [hci_size_pkg::id_w-1:0]                           winner_d;
  logic [hci_size_pkg::id_w-1:0]                           winner_q;
  logic                                                    out_hs;
  logic                                                    out_hs_q;
  logic                                                    any_req_q;

  // output handshake moves the round-robin pointer
  assign out_hs = out_req_o & out_gnt_i;

  // round-robin counter, wraps at nb_chan
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_counter_q <= '0;
    end else if (clear_i) begin
      rr_counter_q <= '0;
    end else if (out_hs) begin
      if (rr_counter_q == (hci_size_pkg::id_w)'(hci_size_pkg::nb_chan - 1)) begin
        rr_counter_q <= '0;
      end else begin
        rr_counter_q <= rr_counter_q + 1'b1;
      end
    end
  end

  // previous winner, plus the two events that allow a new decision
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      winner_q  <= '0;
      out_hs_q  <= 1'b0;
      any_req_q <= 1'b0;
    end else if (clear_i) begin
      winner_q  <= '0;
      out_hs_q  <= 1'b0;
      any_req_q <= 1'b0;
    end else begin
      winner_q  <= winner_d;
      out_hs_q  <= out_hs;
      any_req_q <= |chan_req_i;
    end
  end

  for (genvar k = 0; k < hci_size_pkg::nb_chan; k++) begin : gen_rank
    // rank k is held by this channel, higher rank wins
    assign rank_chan[k] = priority_force_i ? priority_i[k] :
        (hci_size_pkg::id_w)'((rr_counter_q + k) % hci_size_pkg::nb_chan);
  end

  // winner-takes-all over the ranks
  // a waiting winner keeps its slot so a late request cannot overtake it
  // and the output payload stays stable until granted
  always_comb begin
    winner_d = winner_q;
    if (out_hs_q || !any_req_q) begin
      winner_d = rr_counter_q;
      for (int k = 0; k < hci_size_pkg::nb_chan; k++) begin
        if (chan_req_i[rank_chan[k]]) begin
          winner_d = rank_chan[k];
        end
      end
    end
  end

  // forward the winner and tag it with its channel index
  assign out_req_o   = chan_req_i[winner_d];
  assign out_o.add   = chan_payload_i[winner_d].add;
  assign out_o.wen   = chan_payload_i[winner_d].wen;
  assign out_o.be    = chan_payload_i[winner_d].be;
  assign out_o.data  = chan_payload_i[winner_d].data;
  assign out_o.id    = winner_d;

  for (genvar ii = 0; ii < hci_size_pkg::nb_chan; ii++) begin : gen_chan
    // grant only reaches the current winner
    assign chan_gnt_o[ii] = (winner_d == (hci_size_pkg::id_w)'(ii)) &
                            chan_req_i[ii] & out_gnt_i;
    // response goes to the channel named by r_id
    assign chan_r_valid_o[ii] = rsp_valid_i & (rsp_i.r_id == (hci_size_pkg::id_w)'(ii));
    assign chan_r_data_o[ii]  = rsp_i.r_data;
  end

  // back-pressure comes from the addressed channel only
  assign rsp_ready_o = chan_r_ready_i[rsp_i.r_id];

endmodule

// ==== hw/hci_mem_subsys.sv ====
// shared-memory subsystem: four channels into one SRAM bank
// grant to r_valid takes at least 3 cycles, more under contention
// responses return in order here, routing itself is by id
// pulse clear_i only while idle, it empties both FIFOs too
`timescale 1ns/100ps

module hci_mem_subsys (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 clear_i,
  input  logic                                                 priority_force_i,
  input  logic [hci_size_pkg::nb_chan-1:0][hci_size_pkg::id_w-1:0] priority_i,
  input  logic [hci_size_pkg::nb_chan-1:0]                     chan_req_i,
  output logic [hci_size_pkg::nb_chan-1:0]                     chan_gnt_o,
  input  hci_bus_pkg::hci_chan_req_t [hci_size_pkg::nb_chan-1:0] chan_payload_i,
  output logic [hci_size_pkg::nb_chan-1:0]                     chan_r_valid_o,
  output logic [hci_size_pkg::nb_chan-1:0][hci_size_pkg::data_w-1:0] chan_r_data_o,
  input  logic [hci_size_pkg::nb_chan-1:0]                     chan_r_ready_i
);

  // mux to request fifo
  logic                            mux_req;
  logic                            mux_gnt;
  hci_bus_pkg::hci_req_t           mux_out;
  // request fifo to reflector
  logic                            reqf_valid;
  logic                            reqf_ready;
  hci_bus_pkg::hci_req_t           reqf_data;
  // reflector to bank
  logic                            mem_en;
  logic                            mem_we;
  logic [hci_size_pkg::word_w-1:0] mem_addr;
  logic [hci_size_pkg::be_w-1:0]   mem_be;
  logic [hci_size_pkg::data_w-1:0] mem_wdata;
  logic [hci_size_pkg::data_w-1:0] mem_rdata;
  // reflector to response fifo and back to the mux
  logic                            rspf_free;
  logic                            rsp_push;
  hci_bus_pkg::hci_rsp_t           rsp_data;
  logic                            rspf_valid;
  logic                            rspf_ready;
  hci_bus_pkg::hci_rsp_t           rspf_data;

  hci_ooo_mux i_mux (
    .clk_i, .rst_ni, .clear_i, .priority_force_i, .priority_i,
    .chan_req_i, .chan_gnt_o, .chan_r_valid_o, .chan_r_data_o,
    .chan_r_ready_i, .chan_payload_i,
    .out_req_o   (mux_req),    .out_gnt_i (mux_gnt),   .out_o       (mux_out),
    .rsp_valid_i (rspf_valid), .rsp_i     (rspf_data), .rsp_ready_o (rspf_ready)
  );

  // request side, free_o is not needed here
  hci_id_fifo #(.payload_t(hci_bus_pkg::hci_req_t)) i_req_fifo (
    .clk_i, .rst_ni, .clear_i,
    .push_req_i (mux_req),    .push_gnt_o  (mux_gnt),    .push_data_i (mux_out),
    .pop_valid_o(reqf_valid), .pop_ready_i (reqf_ready), .pop_data_o  (reqf_data),
    .free_o     ()
  );

  hci_r_id_filter i_id_filter (
    .clk_i, .rst_ni,
    .req_valid_i (reqf_valid), .req_i      (reqf_data), .req_ready_o (reqf_ready),
    .rsp_free_i  (rspf_free),
    .mem_en_o    (mem_en),     .mem_we_o   (mem_we),    .mem_addr_o  (mem_addr),
    .mem_be_o    (mem_be),     .mem_wdata_o(mem_wdata), .mem_rdata_i (mem_rdata),
    .rsp_push_o  (rsp_push),   .rsp_o      (rsp_data)
  );

  hci_sram_bank i_bank (
    .clk_i, .en_i (mem_en), .we_i (mem_we), .addr_i (mem_addr),
    .be_i (mem_be), .wdata_i (mem_wdata), .rdata_o (mem_rdata)
  );

  // response side, the push always finds the slot reserved through free_o
  hci_id_fifo #(.payload_t(hci_bus_pkg::hci_rsp_t)) i_rsp_fifo (
    .clk_i, .rst_ni, .clear_i,
    .push_req_i (rsp_push),   .push_gnt_o  (),           .push_data_i (rsp_data),
    .pop_valid_o(rspf_valid), .pop_ready_i (rspf_ready), .pop_data_o  (rspf_data),
    .free_o     (rspf_free)
  );

endmodule

// ==== test/tb_clk_gen.sv ====
// clock and reset for the testbench
// 40 ns period, reset low for 3 rising edges, released on a falling edge
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam time         half_period = 20ns;
  localparam int unsigned rst_cycles  = 3;

  initial begin
    clk_o = 1'b0;
    forever #(half_period) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== test/tb_hci_mem_subsys.sv ====
// testbench for the shared-memory subsystem
// inputs change on the falling edge, checks sample on the rising edge
// each channel owns a 16-word window, so the reference memory can follow
// grant order per channel
// bank words are written before any random read reaches them
`timescale 1ns/100ps

module tb_hci_mem_subsys;

  localparam int unsigned win_words   = 16;
  localparam int unsigned win_stride  = hci_size_pkg::mem_words / hci_size_pkg::nb_chan;
  localparam int unsigned gnt_limit   = 300;
  localparam int unsigned drain_limit = 3000;

  logic                                                       clk;
  logic                                                       rst_n;
  logic                                                       clear;
  logic                                                       prio_force;
  logic [hci_size_pkg::nb_chan-1:0][hci_size_pkg::id_w-1:0]   prio;
  logic [hci_size_pkg::nb_chan-1:0]                           chan_req;
  logic [hci_size_pkg::nb_chan-1:0]                           chan_gnt;
  hci_bus_pkg::hci_chan_req_t [hci_size_pkg::nb_chan-1:0]     chan_payload;
  logic [hci_size_pkg::nb_chan-1:0]                           chan_r_valid;
  logic [hci_size_pkg::nb_chan-1:0][hci_size_pkg::data_w-1:0] chan_r_data;
  logic [hci_size_pkg::nb_chan-1:0]                           chan_r_ready;

  // reference memory, expected responses with msb set for reads
  logic [hci_size_pkg::data_w-1:0] ref_mem [hci_size_pkg::mem_words];
  logic [hci_size_pkg::data_w:0]   exp_q [hci_size_pkg::nb_chan][$];
  int unsigned                     last_gnts [$];
  logic                            idle_chk;
  logic                            fair_chk;
  logic                            bp_done;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  hci_mem_subsys hci_mem_subsys_i (
    .clk_i(clk), .rst_ni(rst_n), .clear_i(clear), .priority_force_i(prio_force),
    .priority_i(prio), .chan_req_i(chan_req), .chan_gnt_o(chan_gnt),
    .chan_payload_i(chan_payload), .chan_r_valid_o(chan_r_valid),
    .chan_r_data_o(chan_r_data), .chan_r_ready_i(chan_r_ready)
  );

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  function automatic logic at_most_one(input logic [hci_size_pkg::nb_chan-1:0] v);
    return (v & (v - 1'b1)) == '0;
  endfunction

  function automatic int unsigned outstanding();
    int unsigned n;
    n = 0;
    for (int ch = 0; ch < hci_size_pkg::nb_chan; ch++) begin
      n += exp_q[ch].size();
    end
    return n;
  endfunction

  // byte-enable write rule, reads take the current word
  function automatic void record_grant(input int unsigned ch,
                                       input hci_bus_pkg::hci_chan_req_t pl);
    int unsigned w;
    w = pl.add >> hci_size_pkg::byte_off_w;
    if (pl.wen) begin
      exp_q[ch].push_back({1'b1, ref_mem[w]});
    end else begin
      for (int b = 0; b < hci_size_pkg::be_w; b++) begin
        if (pl.be[b]) begin
          ref_mem[w][b*hci_size_pkg::byte_w +: hci_size_pkg::byte_w] =
              pl.data[b*hci_size_pkg::byte_w +: hci_size_pkg::byte_w];
        end
      end
      exp_q[ch].push_back({1'b0, pl.data});
    end
  endfunction

  // n back-to-back requests, req stays high between them
  // fill writes the whole window once with all bytes enabled
  task automatic run_channel(input int unsigned ch, input int unsigned n, input logic fill);
    hci_bus_pkg::hci_chan_req_t pl;
    int unsigned                word;
    int unsigned                cnt;
    for (int unsigned i = 0; i < n; i++) begin
      word    = ch * win_stride + (fill ? i % win_words : $urandom % win_words);
      pl.add  = (hci_size_pkg::addr_w)'(word * hci_size_pkg::be_w);
      pl.wen  = fill ? 1'b0 : 1'($urandom % 2);
      pl.be   = fill ? '1 : (hci_size_pkg::be_w)'($urandom);
      pl.data = $urandom;
      @(negedge clk);
      chan_payload[ch] = pl;
      chan_req[ch]     = 1'b1;
      cnt = 0;
      @(posedge clk);
      while (!chan_gnt[ch] && cnt < gnt_limit) begin
        cnt++;
        @(posedge clk);
      end
      if (!chan_gnt[ch]) begin
        $display("channel %0d was not granted within %0d cycles", ch, gnt_limit);
        abort_run();
      end
      record_grant(ch, pl);
    end
    @(negedge clk);
    chan_req[ch] = 1'b0;
  endtask

  // one stream per channel bit in mask, four channels
  task automatic run_set(input logic [hci_size_pkg::nb_chan-1:0] mask,
                         input int unsigned n, input logic fill);
    fork
      if (mask[0]) run_channel(0, n, fill);
      if (mask[1]) run_channel(1, n, fill);
      if (mask[2]) run_channel(2, n, fill);
      if (mask[3]) run_channel(3, n, fill);
    join
  endtask

  task automatic drain();
    int unsigned cnt;
    cnt = 0;
    while (outstanding() != 0 && cnt < drain_limit) begin
      cnt++;
      @(negedge clk);
    end
    if (outstanding() != 0) begin
      $display("%0d responses missing after %0d cycles", outstanding(), drain_limit);
      abort_run();
    end
    @(negedge clk);
  endtask

  // random r_ready gaps until the streams are done
  task automatic shake_ready();
    int unsigned cnt;
    cnt = 0;
    while (!bp_done && cnt < drain_limit) begin
      @(negedge clk);
      for (int ch = 0; ch < hci_size_pkg::nb_chan; ch++) begin
        chan_r_ready[ch] = ($urandom % 3) != 0;
      end
      cnt++;
    end
    if (!bp_done) begin
      $display("request streams under back-pressure did not finish in time");
      abort_run();
    end
    @(negedge clk);
    chan_r_ready = '1;
  endtask

  // counter is zero after clear, so rank k is channel k
  task automatic watch_first_grant(input logic [hci_size_pkg::nb_chan-1:0] mask);
    int unsigned pred;
    int unsigned cnt;
    pred = 0;
    for (int k = 0; k < hci_size_pkg::nb_chan; k++) begin
      if (mask[k]) pred = k;
    end
    cnt = 0;
    @(posedge clk);
    while (chan_gnt == '0 && cnt < gnt_limit) begin
      cnt++;
      @(posedge clk);
    end
    assert (chan_gnt == (hci_size_pkg::nb_chan)'(1) << pred) else begin
      $display("Mismatch chan_gnt_o: got 0x%h, expected 0x%h", chan_gnt,
               (hci_size_pkg::nb_chan)'(1) << pred);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    logic [hci_size_pkg::data_w:0] expd;
    int unsigned                   g;
    logic                          seen;
    if (rst_n === 1'b1) begin
      assert (!idle_chk || (chan_gnt == '0 && chan_r_valid == '0)) else begin
        $display("Mismatch chan_gnt_o/chan_r_valid_o: got 0x%h/0x%h, expected 0x0/0x0",
                 chan_gnt, chan_r_valid);
        abort_run();
      end
      assert (at_most_one(chan_gnt) && (chan_gnt & ~chan_req) == '0) else begin
        $display("Mismatch chan_gnt_o: got 0x%h with chan_req_i 0x%h", chan_gnt, chan_req);
        abort_run();
      end
      // top entry of priority_i wins while it requests
      if (prio_force && chan_req[prio[hci_size_pkg::nb_chan-1]] && chan_gnt != '0) begin
        assert (chan_gnt[prio[hci_size_pkg::nb_chan-1]]) else begin
          $display("Mismatch chan_gnt_o: got 0x%h, expected 0x%h", chan_gnt,
                   (hci_size_pkg::nb_chan)'(1) << prio[hci_size_pkg::nb_chan-1]);
          abort_run();
        end
      end
      // no channel twice within four grants while all request
      if (fair_chk && chan_gnt != '0) begin
        g    = 0;
        seen = 1'b0;
        for (int k = 0; k < hci_size_pkg::nb_chan; k++) begin
          if (chan_gnt[k]) g = k;
        end
        foreach (last_gnts[j]) begin
          if (last_gnts[j] == g) seen = 1'b1;
        end
        assert (!(&chan_req) || !seen) else begin
          $display("Mismatch chan_gnt_o: got 0x%h, channel %0d granted again too early",
                   chan_gnt, g);
          abort_run();
        end
        last_gnts.push_back(g);
        if (last_gnts.size() > hci_size_pkg::nb_chan - 1) void'(last_gnts.pop_front());
      end
      assert (at_most_one(chan_r_valid)) else begin
        $display("Mismatch chan_r_valid_o: got 0x%h, expected at most one bit", chan_r_valid);
        abort_run();
      end
      for (int ch = 0; ch < hci_size_pkg::nb_chan; ch++) begin
        if (chan_r_valid[ch] && chan_r_ready[ch]) begin
          assert (exp_q[ch].size() != 0) begin
            expd = exp_q[ch].pop_front();
            // write responses carry no data
            assert (!expd[hci_size_pkg::data_w] ||
                    chan_r_data[ch] == expd[hci_size_pkg::data_w-1:0]) else begin
              $display("Mismatch chan_r_data_o[%0d]: got 0x%h, expected 0x%h", ch,
                       chan_r_data[ch], expd[hci_size_pkg::data_w-1:0]);
              abort_run();
            end
          end else begin
            $display("channel %0d got a response it never asked for", ch);
            abort_run();
          end
        end
      end
    end
  end

  initial begin
    int unsigned                      cnt;
    logic [hci_size_pkg::nb_chan-1:0] clr_masks [5];
    void'($urandom(32'hd7b6_f4f3));
    clear        = 1'b0;
    prio_force   = 1'b0;
    prio         = {2'd1, 2'd0, 2'd3, 2'd2};
    chan_req     = '0;
    chan_payload = '0;
    chan_r_ready = '1;
    idle_chk     = 1'b0;
    fair_chk     = 1'b0;
    bp_done      = 1'b0;
    clr_masks    = '{4'b0101, 4'b1010, 4'b1011, 4'b0011, 4'b0110};
    cnt = 0;
    while (rst_n !== 1'b1 && cnt < 20) begin
      cnt++;
      @(negedge clk);
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      abort_run();
    end
    idle_chk = 1'b1;
    repeat (8) @(negedge clk);
    idle_chk = 1'b0;
    run_set('1, win_words, 1'b1);
    drain();
    run_set('1, 40, 1'b0);
    drain();
    last_gnts.delete();
    fair_chk = 1'b1;
    run_set('1, 16, 1'b0);
    fair_chk = 1'b0;
    drain();
    prio_force = 1'b1;
    run_set('1, 12, 1'b0);
    drain();
    prio_force = 1'b0;
    fork
      begin
        run_set('1, 40, 1'b0);
        bp_done = 1'b1;
      end
      shake_ready();
    join
    drain();
    // clear while idle, then a contested start
    foreach (clr_masks[m]) begin
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      fork
        run_set(clr_masks[m], 2, 1'b0);
        watch_first_grant(clr_masks[m]);
      join
      drain();
    end
    if (outstanding() == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("%0d responses never arrived", outstanding());
      abort_run();
    end
  end

endmodule

// ==== flist.f ====
hw/hci_size_pkg.sv
hw/hci_bus_pkg.sv
hw/hci_sram_bank.sv
hw/hci_id_fifo.sv
hw/hci_r_id_filter.sv
hw/hci_ooo_mux.sv
hw/hci_mem_subsys.sv
test/tb_clk_gen.sv
test/tb_hci_mem_subsys.sv
